// ==== core_params_pkg.sv ====
/* Core sizes, index widths and index types shared by every block
   of the renaming core */

package core_params_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Machine sizes
    localparam int DISPATCH_WIDTH = 2;   // Dispatch and retire width
    localparam int ARCH_REGS      = 32;
    localparam int PHYS_REGS      = 64;
    localparam int ROB_SIZE       = 16;  // Power of two, pointers wrap

    ///////////////////////////////////////////////////////////////////////
    // Index and count widths
    localparam int ARCH_IDX_W  = $clog2(ARCH_REGS);          // 5
    localparam int PHYS_IDX_W  = $clog2(PHYS_REGS);          // 6
    localparam int ROB_IDX_W   = $clog2(ROB_SIZE);           // 4
    localparam int COUNT_W     = $clog2(DISPATCH_WIDTH + 1); // 0..2
    localparam int ROB_COUNT_W = $clog2(ROB_SIZE + 1);       // 0..16

    // Index types
    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
    typedef logic [PHYS_IDX_W-1:0] phys_idx_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

endpackage

// ==== core_types_pkg.sv ====
/* Packed records passed between dispatch, map table, register pool,
   reorder buffer and retire */

package core_types_pkg;

    import core_params_pkg::*;

    ///////////////////////////////////////////////////////////////////////
    // Front end side

    // Decoded instruction offered to dispatch
    typedef struct packed {
        logic      valid;
        arch_idx_t src1;
        arch_idx_t src2;
        arch_idx_t dest;   // Always present
    } dispatch_req_t;

    // Renamed view of one slot
    typedef struct packed {
        phys_idx_t src1_phys;
        phys_idx_t src2_phys;
        phys_idx_t dest_phys;  // Fresh tag from the pool
        phys_idx_t told_phys;  // Previous mapping of dest
    } rename_out_t;

    ///////////////////////////////////////////////////////////////////////
    // Back end side

    typedef struct packed {
        arch_idx_t dest_arch;
        phys_idx_t dest_phys;  // Must be complete to retire
        phys_idx_t told_phys;  // Freed on retire
    } rob_entry_t;

    // Map update, reused for register release (en and phys only)
    typedef struct packed {
        logic      en;
        arch_idx_t arch;
        phys_idx_t phys;
    } map_write_t;

    // Completion broadcast, one cycle pulse
    typedef struct packed {
        logic      valid;
        phys_idx_t tag;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t dest_arch;
        phys_idx_t dest_phys;
        phys_idx_t told_phys;
    } commit_t;

endpackage

// ==== map_table.sv ====
/* Speculative architectural to physical map table, combinational reads
   of current state and slot ordered writes */

module map_table
    import core_params_pkg::*;
    import core_types_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  arch_idx_t  [3*DISPATCH_WIDTH-1:0]  rd_arch,  // src1, src2, dest per slot
    output phys_idx_t  [3*DISPATCH_WIDTH-1:0]  rd_phys,
    input  map_write_t [DISPATCH_WIDTH-1:0]    writes
);

    // One physical tag per architectural register
    phys_idx_t [ARCH_REGS-1:0] map_q;

    ///////////////////////////////////////////////////////////////////////
    // Read ports

    // Reads see the state at the start of the cycle, no write forwarding
    always_comb begin
        for (int i = 0; i < 3*DISPATCH_WIDTH; i++) begin
            rd_phys[i] = map_q[rd_arch[i]];
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Write ports

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_q[a] <= phys_idx_t'(a);  // Identity mapping
            end
        end else begin
            // Later slot issues its update last and wins on a shared dest
            for (int s = 0; s < DISPATCH_WIDTH; s++) begin
                if (writes[s].en) begin
                    map_q[writes[s].arch] <= writes[s].phys;
                end
            end
        end
    end

endmodule

// ==== phys_reg_pool.sv ====
/* Physical register free list and complete list, lowest first allocation,
   release from retire and completion from the broadcast bus */

module phys_reg_pool
    import core_params_pkg::*;
    import core_types_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    output phys_idx_t  [DISPATCH_WIDTH-1:0] alloc_tags,   // Lowest free first
    output logic       [DISPATCH_WIDTH-1:0] alloc_avail,
    input  logic       [COUNT_W-1:0]        alloc_count,  // Tags taken this cycle
    input  map_write_t [DISPATCH_WIDTH-1:0] releases,     // Told tags from retire
    input  cdb_t       [DISPATCH_WIDTH-1:0] cdb,
    output logic       [PHYS_REGS-1:0]      complete_list
);

    logic [PHYS_REGS-1:0] free_q, free_next;
    logic [PHYS_REGS-1:0] complete_q, complete_next;
    logic [PHYS_REGS-1:0] search;  // Free set minus tags already offered

    ///////////////////////////////////////////////////////////////////////
    // Priority search for the lowest free tags

    always_comb begin
        search = free_q;
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            alloc_tags[s]  = '0;
            alloc_avail[s] = 1'b0;
            for (int r = PHYS_REGS-1; r >= 0; r--) begin  // Scan down, lowest hit last
                if (search[r]) begin
                    alloc_tags[s]  = phys_idx_t'(r);
                    alloc_avail[s] = 1'b1;
                end
            end
            if (alloc_avail[s]) search[alloc_tags[s]] = 1'b0;  // Hide from next slot
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Next state of both lists

    always_comb begin
        free_next     = free_q;
        complete_next = complete_q;
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            if (s < int'(alloc_count)) begin
                free_next[alloc_tags[s]]     = 1'b0;
                complete_next[alloc_tags[s]] = 1'b0;  // New value not produced yet
            end
            if (releases[s].en) free_next[releases[s].phys] = 1'b1;
            if (cdb[s].valid)   complete_next[cdb[s].tag]   = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_q     <= {{(PHYS_REGS-ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};  // Upper half free
            complete_q <= {{(PHYS_REGS-ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};  // Mapped regs ready
        end else begin
            free_q     <= free_next;
            complete_q <= complete_next;
        end
    end

    assign complete_list = complete_q;

    // Retire and the broadcast bus only ever name tags still in use
    for (genvar s = 0; s < DISPATCH_WIDTH; s++) begin : g_checks
        a_release_held: assert property (@(posedge clock) disable iff (reset)
            releases[s].en |-> !free_q[releases[s].phys])
            else $error("released register already free");
        a_cdb_held: assert property (@(posedge clock) disable iff (reset)
            cdb[s].valid |-> !free_q[cdb[s].tag])
            else $error("broadcast tag is free");
    end

endmodule

// ==== rob.sv ====
/* Circular reorder buffer, appends at the tail and drops at the head
   in the same edge, exposes the oldest entries to retire */

module rob
    import core_params_pkg::*;
    import core_types_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  rob_entry_t [DISPATCH_WIDTH-1:0] push,
    input  logic       [COUNT_W-1:0]        push_count,  // Entries appended
    output logic       [ROB_COUNT_W-1:0]    free_slots,
    output rob_entry_t [DISPATCH_WIDTH-1:0] head,        // Oldest first
    output logic       [COUNT_W-1:0]        head_count,  // Valid head entries
    input  logic       [COUNT_W-1:0]        pop_count
);

    rob_entry_t [ROB_SIZE-1:0] entries;
    rob_idx_t                  head_q;   // Oldest entry
    rob_idx_t                  tail_q;   // Next free entry
    logic [ROB_COUNT_W-1:0]    count_q;  // Occupancy

    ///////////////////////////////////////////////////////////////////////
    // Head view

    always_comb begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            head[s] = entries[head_q + rob_idx_t'(s)];  // Index wraps at ROB_SIZE
        end
    end

    assign head_count = (count_q >= ROB_COUNT_W'(DISPATCH_WIDTH)) ?
                        COUNT_W'(DISPATCH_WIDTH) : COUNT_W'(count_q);
    assign free_slots = ROB_COUNT_W'(ROB_SIZE) - count_q;

    ///////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clock) begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            if (s < int'(push_count)) begin
                entries[tail_q + rob_idx_t'(s)] <= push[s];
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + rob_idx_t'(pop_count);
            tail_q  <= tail_q + rob_idx_t'(push_count);
            count_q <= count_q + ROB_COUNT_W'(push_count) - ROB_COUNT_W'(pop_count);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Dispatch and retire must respect the buffer bounds

    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        ROB_COUNT_W'(push_count) <= free_slots)
        else $error("push beyond free entries");

    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        ROB_COUNT_W'(pop_count) <= count_q)
        else $error("pop beyond occupancy");

endmodule

// ==== dispatch_unit.sv ====
/* Dispatch count and register renaming of one group, with bypass of
   older in-group destinations into younger slots */

module dispatch_unit
    import core_params_pkg::*;
    import core_types_pkg::*;
(
    input  dispatch_req_t [DISPATCH_WIDTH-1:0]   reqs,
    input  logic          [ROB_COUNT_W-1:0]      rob_free,
    input  phys_idx_t     [DISPATCH_WIDTH-1:0]   alloc_tags,
    input  logic          [DISPATCH_WIDTH-1:0]   alloc_avail,
    output arch_idx_t     [3*DISPATCH_WIDTH-1:0] map_rd_arch,
    input  phys_idx_t     [3*DISPATCH_WIDTH-1:0] map_rd_phys,
    output logic          [COUNT_W-1:0]          disp_count,
    output rename_out_t   [DISPATCH_WIDTH-1:0]   renamed,
    output map_write_t    [DISPATCH_WIDTH-1:0]   map_writes,
    output rob_entry_t    [DISPATCH_WIDTH-1:0]   rob_push
);

    logic prefix_open;  // No slot rejected so far

    ///////////////////////////////////////////////////////////////////////
    // Accepted prefix, limited by ROB entries and free tags

    always_comb begin
        prefix_open = 1'b1;
        disp_count  = '0;
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            if (prefix_open && reqs[s].valid && alloc_avail[s] && (s < int'(rob_free))) begin
                disp_count = COUNT_W'(s + 1);
            end else begin
                prefix_open = 1'b0;  // Everything after a gap waits
            end
        end
    end

    // Map lookups, three per slot
    always_comb begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            map_rd_arch[3*s]   = reqs[s].src1;
            map_rd_arch[3*s+1] = reqs[s].src2;
            map_rd_arch[3*s+2] = reqs[s].dest;  // Gives the told tag
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Tag selection with in-group bypass

    always_comb begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            renamed[s].src1_phys = map_rd_phys[3*s];
            renamed[s].src2_phys = map_rd_phys[3*s+1];
            renamed[s].told_phys = map_rd_phys[3*s+2];
            renamed[s].dest_phys = alloc_tags[s];
            // Older slots in program order, the nearest writer wins
            for (int p = 0; p < s; p++) begin
                if (reqs[p].dest == reqs[s].src1) renamed[s].src1_phys = alloc_tags[p];
                if (reqs[p].dest == reqs[s].src2) renamed[s].src2_phys = alloc_tags[p];
                if (reqs[p].dest == reqs[s].dest) renamed[s].told_phys = alloc_tags[p];
            end
        end
    end

    // Map updates and ROB records, only accepted slots take effect
    always_comb begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            map_writes[s].en      = (s < int'(disp_count));
            map_writes[s].arch    = reqs[s].dest;
            map_writes[s].phys    = alloc_tags[s];
            rob_push[s].dest_arch = reqs[s].dest;
            rob_push[s].dest_phys = alloc_tags[s];
            rob_push[s].told_phys = renamed[s].told_phys;  // ROB writes only push_count
        end
    end

endmodule

// ==== retire_unit.sv ====
/* In-order retire of completed head entries, told register release and
   registered commit packets */

module retire_unit
    import core_params_pkg::*;
    import core_types_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  rob_entry_t [DISPATCH_WIDTH-1:0] head,
    input  logic       [COUNT_W-1:0]        head_count,
    input  logic       [PHYS_REGS-1:0]      complete_list,
    output logic       [COUNT_W-1:0]        pop_count,
    output map_write_t [DISPATCH_WIDTH-1:0] releases,
    output commit_t    [DISPATCH_WIDTH-1:0] commits
);

    logic prefix_open;  // All older head entries retire

    // Stop at the first empty or incomplete entry
    always_comb begin
        prefix_open = 1'b1;
        pop_count   = '0;
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            if (prefix_open && (s < int'(head_count)) && complete_list[head[s].dest_phys]) begin
                pop_count = COUNT_W'(s + 1);
            end else begin
                prefix_open = 1'b0;
            end
        end
    end

    // Superseded tags go back to the pool at this edge
    always_comb begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            releases[s].en   = (s < int'(pop_count));
            releases[s].arch = head[s].dest_arch;
            releases[s].phys = head[s].told_phys;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Commit packets, one cycle after retire
    always_ff @(posedge clock) begin
        if (reset) begin
            commits <= '0;
        end else begin
            for (int s = 0; s < DISPATCH_WIDTH; s++) begin
                commits[s] <= '{valid:     (s < int'(pop_count)),
                                dest_arch: head[s].dest_arch,
                                dest_phys: head[s].dest_phys,
                                told_phys: head[s].told_phys};
            end
        end
    end

endmodule

// ==== rename_core.sv ====
/* Top of the renaming core, connects dispatch, map table, register pool,
   reorder buffer and retire */

module rename_core
    import core_params_pkg::*;
    import core_types_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  dispatch_req_t [DISPATCH_WIDTH-1:0] reqs,        // Valid slots contiguous from 0
    input  cdb_t          [DISPATCH_WIDTH-1:0] cdb,
    output logic          [COUNT_W-1:0]        disp_count,  // Same cycle as reqs
    output rename_out_t   [DISPATCH_WIDTH-1:0] renamed,
    output commit_t       [DISPATCH_WIDTH-1:0] commits
);

    // Rename side
    arch_idx_t  [3*DISPATCH_WIDTH-1:0] map_rd_arch;
    phys_idx_t  [3*DISPATCH_WIDTH-1:0] map_rd_phys;
    map_write_t [DISPATCH_WIDTH-1:0]   map_writes;
    phys_idx_t  [DISPATCH_WIDTH-1:0]   alloc_tags;
    logic       [DISPATCH_WIDTH-1:0]   alloc_avail;
    logic       [PHYS_REGS-1:0]        complete_list;

    // ROB and retire side
    logic       [ROB_COUNT_W-1:0]      rob_free;
    rob_entry_t [DISPATCH_WIDTH-1:0]   rob_push;
    rob_entry_t [DISPATCH_WIDTH-1:0]   rob_head;
    logic       [COUNT_W-1:0]          head_count;
    logic       [COUNT_W-1:0]          pop_count;
    map_write_t [DISPATCH_WIDTH-1:0]   releases;

    ///////////////////////////////////////////////////////////////////////
    // Stages

    dispatch_unit dispatch_instance (
        .reqs(reqs), .rob_free(rob_free),
        .alloc_tags(alloc_tags), .alloc_avail(alloc_avail),
        .map_rd_arch(map_rd_arch), .map_rd_phys(map_rd_phys),
        .disp_count(disp_count), .renamed(renamed),
        .map_writes(map_writes), .rob_push(rob_push)
    );

    map_table map_table_instance (
        .clock(clock), .reset(reset),
        .rd_arch(map_rd_arch), .rd_phys(map_rd_phys), .writes(map_writes)
    );

    phys_reg_pool pool_instance (
        .clock(clock), .reset(reset),
        .alloc_tags(alloc_tags), .alloc_avail(alloc_avail),
        .alloc_count(disp_count),  // Every accepted slot takes a tag
        .releases(releases), .cdb(cdb), .complete_list(complete_list)
    );

    rob rob_instance (
        .clock(clock), .reset(reset),
        .push(rob_push), .push_count(disp_count), .free_slots(rob_free),
        .head(rob_head), .head_count(head_count), .pop_count(pop_count)
    );

    retire_unit retire_instance (
        .clock(clock), .reset(reset),
        .head(rob_head), .head_count(head_count), .complete_list(complete_list),
        .pop_count(pop_count), .releases(releases), .commits(commits)
    );

endmodule

// ==== tb_rename_core.sv ====
/* Testbench for the renaming core, a reference model of map, live tags, reorder queue
   and random completions, checked by concurrent assertions */

module tb_rename_core
    import core_params_pkg::*;
    import core_types_pkg::*;
();

    typedef enum int {GEN_IDLE, GEN_RANDOM, GEN_BYPASS, GEN_FULL} gen_mode_t;

    logic                               clock;
    logic                               reset;
    dispatch_req_t [DISPATCH_WIDTH-1:0] reqs;
    cdb_t          [DISPATCH_WIDTH-1:0] cdb;
    logic          [COUNT_W-1:0]        disp_count;
    rename_out_t   [DISPATCH_WIDTH-1:0] renamed;
    commit_t       [DISPATCH_WIDTH-1:0] commits;

    // Reference model
    phys_idx_t                    model_map [ARCH_REGS];
    logic [PHYS_REGS-1:0]         live;         // Mapped or still needed by the ROB
    logic [PHYS_REGS-1:0]         done_set;     // Value produced
    logic [PHYS_REGS-1:0]         ever_freed;   // Released at least once
    rob_entry_t                   rob_q [$];    // Dispatched, not retired
    phys_idx_t                    pending [$];  // Allocated, not completed
    int                           rob_used;
    commit_t [DISPATCH_WIDTH-1:0] exp_commits;  // Retired in the previous cycle

    // Expectations of the current cycle
    logic [PHYS_REGS-1:0]             free_vec;
    int                               exp_disp;
    rename_out_t [DISPATCH_WIDTH-1:0] exp_ren;

    // Control and statistics
    gen_mode_t gen_mode;
    logic      cdb_on;
    int        seed = 69;
    int        error_count = 0;
    int        test_errors = 0;
    int        tests_done = 0;
    int        disp_total = 0;
    int        commit_total = 0;
    int        bypass_hits = 0;
    int        ooo_count = 0;
    int        reuse_count = 0;
    int        cap_count = 0;
    phys_idx_t first_dest [DISPATCH_WIDTH];

    rename_core i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ///////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic int rand_below(input int bound);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % bound;
    endfunction

    function automatic bit drained();
        return rob_used == 0 && exp_commits == '0;
    endfunction

    task automatic check_failed(input string msg);
        error_count++;
        $display("CHECK FAILED %0t: %s", $time, msg);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s, %0d checks failed so far", what, error_count);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s finished, %0d failed checks", tests_done, name,
                 error_count - test_errors);
        test_errors = error_count;
    endtask

    task automatic wait_for_drain(input string what);
        int n;
        @(negedge clock);  // Lets the last driven group land
        for (n = 0; n < 3000 && !drained(); n++) @(negedge clock);
        if (!drained()) abort_on_timeout(what);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Model expectations, lowest free first and in-group bypass

    always_comb begin
        int found;
        found    = 0;
        free_vec = ~live;
        exp_ren  = '0;
        for (int r = 0; r < PHYS_REGS; r++) begin
            if (free_vec[r] && found < DISPATCH_WIDTH) begin
                exp_ren[found].dest_phys = phys_idx_t'(r);
                found++;
            end
        end
        exp_disp = 0;  // Longest valid prefix that fits
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            if (exp_disp == s && reqs[s].valid && s < found && rob_used + s < ROB_SIZE) begin
                exp_disp = s + 1;
            end
        end
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            exp_ren[s].src1_phys = model_map[reqs[s].src1];
            exp_ren[s].src2_phys = model_map[reqs[s].src2];
            exp_ren[s].told_phys = model_map[reqs[s].dest];
            for (int p = 0; p < s; p++) begin  // Older slot's fresh tag beats the map
                if (reqs[s].src1 == reqs[p].dest) exp_ren[s].src1_phys = exp_ren[p].dest_phys;
                if (reqs[s].src2 == reqs[p].dest) exp_ren[s].src2_phys = exp_ren[p].dest_phys;
                if (reqs[s].dest == reqs[p].dest) exp_ren[s].told_phys = exp_ren[p].dest_phys;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus, next group and completions

    task automatic drive_inputs();
        dispatch_req_t [DISPATCH_WIDTH-1:0] next_reqs;
        cdb_t          [DISPATCH_WIDTH-1:0] next_cdb;
        int                                 n;
        int                                 idx;
        next_reqs = '0;
        next_cdb  = '0;
        n = 0;
        if (gen_mode == GEN_RANDOM) n = rand_below(DISPATCH_WIDTH + 1);
        else if (gen_mode != GEN_IDLE) n = DISPATCH_WIDTH;
        for (int s = 0; s < n; s++) begin  // Contiguous from slot 0
            next_reqs[s].valid = 1'b1;
            next_reqs[s].src1  = arch_idx_t'(rand_below(ARCH_REGS));
            next_reqs[s].src2  = arch_idx_t'(rand_below(ARCH_REGS));
            next_reqs[s].dest  = arch_idx_t'(rand_below(ARCH_REGS));
        end
        if (gen_mode == GEN_BYPASS) begin
            next_reqs[1].src1 = next_reqs[0].dest;  // Slot 1 reads slot 0's result
            if (rand_below(2) == 1) next_reqs[1].dest = next_reqs[0].dest;
            if (rand_below(3) == 0) next_reqs[1].src2 = next_reqs[0].dest;
        end
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            if (cdb_on && pending.size() > 0 && rand_below(8) < 3) begin
                idx = rand_below(pending.size());
                if (idx != 0) ooo_count++;  // Younger tag finishes first
                next_cdb[s].valid = 1'b1;
                next_cdb[s].tag   = pending[idx];
                pending.delete(idx);
            end
        end
        reqs <= next_reqs;
        cdb  <= next_cdb;
    endtask

    // Model update at each edge, retire before completion before dispatch
    always @(posedge clock) begin
        int                               taken;
        int                               n_ret;
        rename_out_t [DISPATCH_WIDTH-1:0] grant;
        rob_entry_t                       entry;
        if (reset) begin
            for (int a = 0; a < ARCH_REGS; a++) model_map[a] = phys_idx_t'(a);
            live        = {{(PHYS_REGS-ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};
            done_set    = live;  // Initial mappings hold values
            ever_freed  = '0;
            rob_q.delete();
            pending.delete();
            rob_used    = 0;
            exp_commits = '0;
            reqs <= '0;
            cdb  <= '0;
        end else begin
            taken = exp_disp;  // Snapshot before the model moves
            grant = exp_ren;
            n_ret = 0;
            for (int s = 0; s < DISPATCH_WIDTH; s++) begin
                if (commits[s].valid) commit_total++;  // Commit packets seen at the DUT
            end
            while (n_ret < DISPATCH_WIDTH && n_ret < rob_q.size() &&
                   done_set[rob_q[n_ret].dest_phys]) begin
                n_ret++;
            end
            exp_commits = '0;  // Visible one cycle after retire
            for (int s = 0; s < n_ret; s++) begin
                entry = rob_q.pop_front();
                exp_commits[s].valid     = 1'b1;
                exp_commits[s].dest_arch = entry.dest_arch;
                exp_commits[s].dest_phys = entry.dest_phys;
                exp_commits[s].told_phys = entry.told_phys;
                live[entry.told_phys]       = 1'b0;  // Superseded value dies
                ever_freed[entry.told_phys] = 1'b1;
            end
            for (int s = 0; s < DISPATCH_WIDTH; s++) begin
                if (cdb[s].valid) done_set[cdb[s].tag] = 1'b1;
            end
            for (int s = 0; s < taken; s++) begin
                entry.dest_arch = reqs[s].dest;
                entry.dest_phys = grant[s].dest_phys;
                entry.told_phys = grant[s].told_phys;
                rob_q.push_back(entry);
                model_map[reqs[s].dest]      = grant[s].dest_phys;  // Later slot wins
                live[grant[s].dest_phys]     = 1'b1;
                done_set[grant[s].dest_phys] = 1'b0;
                pending.push_back(grant[s].dest_phys);
                if (ever_freed[grant[s].dest_phys]) reuse_count++;
                if (disp_total < DISPATCH_WIDTH) first_dest[disp_total] = renamed[s].dest_phys;
                disp_total++;
            end
            if (gen_mode == GEN_FULL) cap_count += int'(disp_count);  // As accepted by the DUT
            if (taken == DISPATCH_WIDTH && reqs[1].src1 == reqs[0].dest) bypass_hits++;
            rob_used = rob_q.size();
            drive_inputs();
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Checks

    a_disp_count: assert property (@(posedge clock) disable iff (reset)
        int'(disp_count) == exp_disp)
        else check_failed($sformatf("disp_count %0d, model %0d", disp_count, exp_disp));

    for (genvar s = 0; s < DISPATCH_WIDTH; s++) begin : g_slot_checks
        a_renamed: assert property (@(posedge clock) disable iff (reset)
            (s < int'(disp_count)) |-> renamed[s] == exp_ren[s])
            else check_failed($sformatf("slot %0d renamed tags differ from model", s));
        a_fresh_dest: assert property (@(posedge clock) disable iff (reset)
            (s < int'(disp_count)) |-> free_vec[renamed[s].dest_phys])
            else check_failed($sformatf("slot %0d dest tag is still live", s));
        a_commit: assert property (@(posedge clock) disable iff (reset)
            (commits[s].valid || exp_commits[s].valid) |-> commits[s] == exp_commits[s])
            else check_failed($sformatf("commit slot %0d out of program order", s));
    end

    // Slot 1 sees slot 0's new tag in the same cycle
    a_bypass_src1: assert property (@(posedge clock) disable iff (reset)
        (disp_count == 2 && reqs[1].src1 == reqs[0].dest) |->
        renamed[1].src1_phys == renamed[0].dest_phys)
        else check_failed("slot 1 src1 missed slot 0 bypass");
    a_bypass_src2: assert property (@(posedge clock) disable iff (reset)
        (disp_count == 2 && reqs[1].src2 == reqs[0].dest) |->
        renamed[1].src2_phys == renamed[0].dest_phys)
        else check_failed("slot 1 src2 missed slot 0 bypass");
    a_bypass_told: assert property (@(posedge clock) disable iff (reset)
        (disp_count == 2 && reqs[1].dest == reqs[0].dest) |->
        renamed[1].told_phys == renamed[0].dest_phys)
        else check_failed("slot 1 told tag missed slot 0 bypass");

    ///////////////////////////////////////////////////////////////////////
    // Test sequence, controlled on the falling edge

    initial begin
        int wait_n;
        int mark;
        reset    = 1'b1;
        reqs     = '0;
        cdb      = '0;
        gen_mode = GEN_IDLE;
        cdb_on   = 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);
        gen_mode = GEN_FULL;  // First group, two slots
        for (wait_n = 0; wait_n < 100 && disp_total < DISPATCH_WIDTH; wait_n++) @(negedge clock);
        if (disp_total < DISPATCH_WIDTH) abort_on_timeout("the first group after reset");
        gen_mode = GEN_IDLE;
        assert (first_dest[0] == phys_idx_t'(ARCH_REGS) &&
                first_dest[1] == phys_idx_t'(ARCH_REGS + 1))
            else check_failed("first destinations are not the lowest free registers");
        cdb_on = 1'b1;
        wait_for_drain("the reset test to drain");
        finish_test("reset state");

        gen_mode = GEN_BYPASS;
        mark     = bypass_hits;
        for (wait_n = 0; wait_n < 3000 && bypass_hits < mark + 40; wait_n++) @(negedge clock);
        if (bypass_hits < mark + 40) abort_on_timeout("bypass groups to dispatch");
        gen_mode = GEN_IDLE;
        wait_for_drain("the bypass test to drain");
        finish_test("slot bypass");

        gen_mode = GEN_RANDOM;
        mark     = disp_total;
        for (wait_n = 0; wait_n < 6000 && disp_total < mark + 400; wait_n++) @(negedge clock);
        if (disp_total < mark + 400) abort_on_timeout("random groups to dispatch");
        finish_test("tag uniqueness");

        gen_mode = GEN_IDLE;
        wait_for_drain("random traffic to commit");
        assert (ooo_count > 0 && commit_total == disp_total)
            else check_failed("commits incomplete or no out of order completion seen");
        finish_test("in-order commit");

        cdb_on    = 1'b0;  // Completions withheld
        cap_count = 0;
        gen_mode  = GEN_FULL;
        for (wait_n = 0; wait_n < 200 && !(reqs[0].valid && disp_count == '0); wait_n++) begin
            @(negedge clock);
        end
        if (!(reqs[0].valid && disp_count == '0)) abort_on_timeout("dispatch to stall");
        assert (cap_count == ROB_SIZE)
            else check_failed($sformatf("stall after %0d instructions", cap_count));
        repeat (4) @(negedge clock);
        assert (cap_count == ROB_SIZE) else check_failed("dispatch went on with a full ROB");
        mark   = reuse_count;
        cdb_on = 1'b1;
        for (wait_n = 0; wait_n < 3000 &&
             !(cap_count >= ROB_SIZE + 40 && reuse_count > mark); wait_n++) begin
            @(negedge clock);
        end
        if (!(cap_count >= ROB_SIZE + 40 && reuse_count > mark)) begin
            abort_on_timeout("dispatch to resume with reused tags");
        end
        gen_mode = GEN_IDLE;
        wait_for_drain("the capacity test to drain");
        finish_test("capacity");

        $display("%0d tests, %0d dispatched, %0d committed, %0d failed checks",
                 tests_done, disp_total, commit_total, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== files.f ====
core_params_pkg.sv
core_types_pkg.sv
map_table.sv
phys_reg_pool.sv
rob.sv
dispatch_unit.sv
retire_unit.sv
rename_core.sv
tb_rename_core.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  # Packages first, then the stages and the top level
  - core_params_pkg.sv
  - core_types_pkg.sv
  - map_table.sv
  - phys_reg_pool.sv
  - rob.sv
  - dispatch_unit.sv
  - retire_unit.sv
  - rename_core.sv
  - target: test
    files:
      - tb_rename_core.sv
